// File: filelist.f
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/openmips.sv
verif/tb_clock_gen.sv
verif/openmips_asserts.sv
verif/openmips_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = openmips_tb
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

.PHONY: simulate clean

// File: verif/openmips_tb.sv
////////////////////////////////////////////////////////////////////////////
// openmips_tb
// Random program over the kept MIPS32 subset, ROM model, sequential
// reference model and a checker on the register write port.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module openmips_tb import mips_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int prog_len      = 200;
    localparam int reset_timeout = 50;
    localparam int run_timeout   = prog_len + 60;
    localparam int drain_cycles  = 8;
    localparam int wb_latency    = 4;

    logic                  clk;
    logic                  rst_n;
    logic [data_w-1:0]     rom_data;
    logic [data_w-1:0]     rom_addr;
    logic                  rom_ce;
    logic                  wb_we;
    logic [reg_addr_w-1:0] wb_addr;
    logic [data_w-1:0]     wb_data;

    logic [data_w-1:0]     prog [0:prog_len-1];
    logic [36:0]           exp_q [$];      // {register, data}

    int                    seed;
    int                    value_errs;
    int                    timing_errs;
    int                    flow_errs;
    int                    first_wr_idx;
    int                    first_fetch;
    int                    n_written;
    bit                    first_seen;
    logic [data_w-1:0]     next_addr;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    openmips u_openmips (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .rom_data_i (rom_data),
        .rom_addr_o (rom_addr),
        .rom_ce_o   (rom_ce),
        .wb_we_o    (wb_we),
        .wb_addr_o  (wb_addr),
        .wb_data_o  (wb_data)
    );

    // instruction rom, zero past the program end
    initial begin
        rom_data = '0;
        forever begin
            @(negedge clk);
            if (rom_ce && rom_addr[31:2] < prog_len)
                rom_data = prog[rom_addr[31:2]];
            else
                rom_data = '0;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic build_program();
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        bit          hilo_prev;
        hilo_prev = 1'b0;
        for (int i = 0; i < prog_len; i++) begin
            kind = rand_below(15);
            if (hilo_prev && rand_below(2) == 0)
                kind = 11 + rand_below(2);     // read hi/lo right after a write
            rs  = 5'(rand_below(8));
            rt  = 5'(rand_below(8));
            rd  = 5'(rand_below(8));
            imm = 16'($random(seed));
            case (kind)
                0:  prog[i] = {op_special, rs, rt, rd, 5'd0, fn_addu};
                1:  prog[i] = {op_special, rs, rt, rd, 5'd0, fn_subu};
                2:  prog[i] = {op_special, rs, rt, rd, 5'd0, fn_and};
                3:  prog[i] = {op_special, rs, rt, rd, 5'd0, fn_or};
                4:  prog[i] = {op_special, rs, rt, rd, 5'd0, fn_xor};
                5:  prog[i] = {op_ori, rs, rt, imm};
                6:  prog[i] = {op_andi, rs, rt, imm};
                7:  prog[i] = {op_xori, rs, rt, imm};
                8:  prog[i] = {op_addiu, rs, rt, imm};
                9:  prog[i] = {op_lui, 5'd0, rt, imm};
                10: prog[i] = {op_special, rs, rt, 10'd0, fn_multu};
                11: prog[i] = {op_special, 10'd0, rd, 5'd0, fn_mfhi};
                12: prog[i] = {op_special, 10'd0, rd, 5'd0, fn_mflo};
                13: prog[i] = {op_special, rs, 15'd0, fn_mthi};
                default: prog[i] = {op_special, rs, 15'd0, fn_mtlo};
            endcase
            hilo_prev = (kind == 10 || kind == 13 || kind == 14);
        end
    endtask

    // executes the program one instruction at a time
    task automatic run_model();
        logic [31:0] regs [0:31];
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] zimm;
        logic [31:0] simm;
        logic [63:0] prod;
        logic [4:0]  dst;
        logic        wr;
        for (int r = 0; r < 32; r++) regs[r] = '0;
        hi = '0;
        lo = '0;
        first_wr_idx = -1;
        for (int i = 0; i < prog_len; i++) begin
            inst = prog[i];
            a    = regs[inst[25:21]];
            b    = regs[inst[20:16]];
            zimm = {16'h0000, inst[15:0]};
            simm = {{16{inst[15]}}, inst[15:0]};
            dst  = inst[20:16];
            wr   = 1'b1;
            res  = '0;
            case (inst[31:26])
                op_ori:   res = a | zimm;
                op_andi:  res = a & zimm;
                op_xori:  res = a ^ zimm;
                op_addiu: res = a + simm;
                op_lui:   res = {inst[15:0], 16'h0000};
                op_special: begin
                    dst = inst[15:11];
                    case (inst[5:0])
                        fn_addu: res = a + b;
                        fn_subu: res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_xor:  res = a ^ b;
                        fn_mfhi: res = hi;
                        fn_mflo: res = lo;
                        fn_multu: begin
                            prod = {32'h0, a} * {32'h0, b};
                            hi   = prod[63:32];
                            lo   = prod[31:0];
                            wr   = 1'b0;
                        end
                        fn_mthi: begin
                            hi = a;
                            wr = 1'b0;
                        end
                        fn_mtlo: begin
                            lo = a;
                            wr = 1'b0;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_q.push_back({dst, res});
                if (first_wr_idx < 0)
                    first_wr_idx = i;
            end
        end
    endtask

    task automatic check_fetch(input int cyc);
        if (!rom_ce) begin
            assert (next_addr == pc_reset) else begin
                $display("rom_ce_o dropped after fetching had started");
                flow_errs++;
            end
        end else begin
            assert (rom_addr == next_addr) else begin
                $display("Error fetch_address: expected %h, actual %h", next_addr, rom_addr);
                value_errs++;
            end
            if (first_fetch < 0 && first_wr_idx >= 0 && rom_addr == 32'(first_wr_idx) * 4)
                first_fetch = cyc;
            next_addr = rom_addr + pc_step;
        end
    endtask

    task automatic check_writeback(input int cyc);
        logic [36:0] head;
        if (wb_we) begin
            if (exp_q.size() == 0) begin
                $display("unexpected write to register %0d", wb_addr);
                flow_errs++;
            end else begin
                head = exp_q.pop_front();
                if (!first_seen) begin
                    first_seen = 1'b1;
                    assert (cyc - first_fetch == wb_latency) else begin
                        $display("Error first_wb_latency: expected %0d, actual %0d",
                                 wb_latency, cyc - first_fetch);
                        timing_errs++;
                    end
                end
                assert (wb_addr == head[36:32]) else begin
                    $display("Error wb_addr #%0d: expected %0d, actual %0d",
                             n_written, head[36:32], wb_addr);
                    value_errs++;
                end
                assert (wb_data == head[31:0]) else begin
                    $display("Error wb_data #%0d: expected %h, actual %h",
                             n_written, head[31:0], wb_data);
                    value_errs++;
                end
                n_written++;
            end
        end
    endtask

    initial begin
        int waited;
        int cyc;
        int drain;
        seed        = 41;
        value_errs  = 0;
        timing_errs = 0;
        flow_errs   = 0;
        first_fetch = -1;
        first_seen  = 1'b0;
        n_written   = 0;
        next_addr   = pc_reset;
        build_program();
        run_model();

        // reset moves on the falling edge, so look at it on the rising one
        waited = 0;
        while (rst_n !== 1'b1 && waited < reset_timeout) begin
            @(posedge clk);
            waited++;
            if (rst_n === 1'b0) begin
                assert (!rom_ce && !wb_we) else begin
                    $display("rom_ce_o or wb_we_o high during reset");
                    flow_errs++;
                end
            end
        end
        if (rst_n !== 1'b1) begin
            $display("timeout waiting for reset release");
            flow_errs++;
        end

        cyc   = 0;
        drain = 0;
        while ((exp_q.size() != 0 || drain < drain_cycles) && cyc < run_timeout) begin
            @(negedge clk);
            cyc++;
            if (exp_q.size() == 0)
                drain++;
            check_fetch(cyc);
            check_writeback(cyc);
        end
        if (exp_q.size() != 0) begin
            $display("timeout with %0d expected register writes missing", exp_q.size());
            flow_errs++;
        end

        $display("errors: value %0d, timing %0d, flow %0d", value_errs, timing_errs,
                 flow_errs);
        if (value_errs + timing_errs + flow_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/openmips_asserts.sv
////////////////////////////////////////////////////////////////////////////
// openmips_asserts
// Concurrent checks on the instruction ROM port and the register
// write port of the pipeline top.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module openmips_asserts import mips_pkg::*; (
    input  wire                    clk_i,
    input  wire                    rst_n_i,
    input  wire                    rom_ce_i,
    input  wire   [data_w-1:0]     rom_addr_i,
    input  wire                    wb_we_i,
    input  wire   [reg_addr_w-1:0] wb_addr_i
);
    timeunit 1ns;
    timeprecision 1ps;

    ce_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !rom_ce_i)
        else $error("rom_ce_o high while in reset");

    addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rom_ce_i |-> rom_addr_i[1:0] == 2'b00)
        else $error("rom_addr_o not word aligned");

    // sequential fetch, one word per cycle
    addr_steps: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rom_ce_i && $past(rom_ce_i) |-> rom_addr_i == $past(rom_addr_i) + pc_step)
        else $error("rom_addr_o did not advance by one word");

    no_write_to_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_we_i |-> wb_addr_i != '0)
        else $error("register write to register zero");

endmodule

bind openmips openmips_asserts u_asserts (
    .clk_i      (clk),
    .rst_n_i    (rst_n_i),
    .rom_ce_i   (rom_ce_o),
    .rom_addr_i (rom_addr_o),
    .wb_we_i    (wb_we_o),
    .wb_addr_i  (wb_addr_o)
);

`default_nettype wire

// File: verif/tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// tb_clock_gen
// 10 ns testbench clock and an active-low reset held for 8 cycles.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);          // release away from the active edge
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/openmips.sv
////////////////////////////////////////////////////////////////////////////
// openmips
// Five-stage MIPS32 subset pipeline top. Exports the instruction ROM
// port and the register file write port.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module openmips import mips_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire   [data_w-1:0]     rom_data_i,
    output wire   [data_w-1:0]     rom_addr_o,   // byte address
    output wire                    rom_ce_o,
    output wire                    wb_we_o,
    output wire   [reg_addr_w-1:0] wb_addr_o,
    output wire   [data_w-1:0]     wb_data_o
);

    logic [data_w-1:0]     id_inst;
    logic                  id_re1;
    logic                  id_re2;
    logic [reg_addr_w-1:0] id_raddr1;
    logic [reg_addr_w-1:0] id_raddr2;
    logic [data_w-1:0]     id_rdata1;
    logic [data_w-1:0]     id_rdata2;
    alu_op_e               id_alu_op;
    logic [data_w-1:0]     id_op1;
    logic [data_w-1:0]     id_op2;
    logic [reg_addr_w-1:0] id_waddr;
    logic                  id_we;

    logic                  ex_we;
    logic [reg_addr_w-1:0] ex_waddr;
    logic [data_w-1:0]     ex_wdata;
    logic                  ex_whilo;
    logic [data_w-1:0]     ex_hi;
    logic [data_w-1:0]     ex_lo;

    logic                  mem_we;
    logic [reg_addr_w-1:0] mem_waddr;
    logic [data_w-1:0]     mem_wdata;
    logic                  mem_whilo;
    logic [data_w-1:0]     mem_hi;
    logic [data_w-1:0]     mem_lo;

    logic                  wb_whilo;
    logic [data_w-1:0]     wb_hi;
    logic [data_w-1:0]     wb_lo;
    logic [data_w-1:0]     hi;
    logic [data_w-1:0]     lo;

    fetch_stage u_fetch (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .id_pc_o    (),
        .id_inst_o  (id_inst)
    );

    decode_stage u_decode (
        .inst_i      (id_inst),
        .rdata1_i    (id_rdata1),
        .rdata2_i    (id_rdata2),
        .ex_we_i     (ex_we),
        .ex_waddr_i  (ex_waddr),
        .ex_wdata_i  (ex_wdata),
        .mem_we_i    (mem_we),
        .mem_waddr_i (mem_waddr),
        .mem_wdata_i (mem_wdata),
        .re1_o       (id_re1),
        .raddr1_o    (id_raddr1),
        .re2_o       (id_re2),
        .raddr2_o    (id_raddr2),
        .alu_op_o    (id_alu_op),
        .op1_o       (id_op1),
        .op2_o       (id_op2),
        .waddr_o     (id_waddr),
        .we_o        (id_we)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we_i     (wb_we_o),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o),
        .re1_i    (id_re1),
        .raddr1_i (id_raddr1),
        .re2_i    (id_re2),
        .raddr2_i (id_raddr2),
        .rdata1_o (id_rdata1),
        .rdata2_o (id_rdata2)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .alu_op_i    (id_alu_op),
        .op1_i       (id_op1),
        .op2_i       (id_op2),
        .waddr_i     (id_waddr),
        .we_i        (id_we),
        .hi_i        (hi),
        .lo_i        (lo),
        .mem_whilo_i (mem_whilo),
        .mem_hi_i    (mem_hi),
        .mem_lo_i    (mem_lo),
        .wb_whilo_i  (wb_whilo),
        .wb_hi_i     (wb_hi),
        .wb_lo_i     (wb_lo),
        .ex_we_o     (ex_we),
        .ex_waddr_o  (ex_waddr),
        .ex_wdata_o  (ex_wdata),
        .whilo_o     (ex_whilo),
        .hi_o        (ex_hi),
        .lo_o        (ex_lo)
    );

    writeback_stage u_writeback (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ex_we_i     (ex_we),
        .ex_waddr_i  (ex_waddr),
        .ex_wdata_i  (ex_wdata),
        .ex_whilo_i  (ex_whilo),
        .ex_hi_i     (ex_hi),
        .ex_lo_i     (ex_lo),
        .mem_we_o    (mem_we),
        .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata),
        .mem_whilo_o (mem_whilo),
        .mem_hi_o    (mem_hi),
        .mem_lo_o    (mem_lo),
        .wb_we_o     (wb_we_o),
        .wb_waddr_o  (wb_addr_o),
        .wb_wdata_o  (wb_data_o),
        .wb_whilo_o  (wb_whilo),
        .wb_hi_o     (wb_hi),
        .wb_lo_o     (wb_lo),
        .hi_o        (hi),
        .lo_o        (lo)
    );

endmodule

`default_nettype wire

// File: rtl/writeback_stage.sv
////////////////////////////////////////////////////////////////////////////
// writeback_stage
// Execute/memory and memory/writeback pipeline registers, and the
// committed HI/LO pair. The memory stage holds no memory access.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module writeback_stage import mips_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    ex_we_i,
    input  wire   [reg_addr_w-1:0] ex_waddr_i,
    input  wire   [data_w-1:0]     ex_wdata_i,
    input  wire                    ex_whilo_i,
    input  wire   [data_w-1:0]     ex_hi_i,
    input  wire   [data_w-1:0]     ex_lo_i,
    output logic                   mem_we_o,
    output logic  [reg_addr_w-1:0] mem_waddr_o,
    output logic  [data_w-1:0]     mem_wdata_o,
    output logic                   mem_whilo_o,
    output logic  [data_w-1:0]     mem_hi_o,
    output logic  [data_w-1:0]     mem_lo_o,
    output logic                   wb_we_o,
    output logic  [reg_addr_w-1:0] wb_waddr_o,
    output logic  [data_w-1:0]     wb_wdata_o,
    output logic                   wb_whilo_o,
    output logic  [data_w-1:0]     wb_hi_o,
    output logic  [data_w-1:0]     wb_lo_o,
    output logic  [data_w-1:0]     hi_o,
    output logic  [data_w-1:0]     lo_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_we_o    <= 1'b0;
            mem_whilo_o <= 1'b0;
            wb_we_o     <= 1'b0;
            wb_whilo_o  <= 1'b0;
            hi_o        <= '0;
            lo_o        <= '0;
        end else begin
            mem_we_o    <= ex_we_i;
            mem_whilo_o <= ex_whilo_i;
            wb_we_o     <= mem_we_o;
            wb_whilo_o  <= mem_whilo_o;
            if (wb_whilo_o) begin     // hi/lo commit
                hi_o <= wb_hi_o;
                lo_o <= wb_lo_o;
            end
        end
    end

    // payload of both stages
    always_ff @(posedge clk) begin
        mem_waddr_o <= ex_waddr_i;
        mem_wdata_o <= ex_wdata_i;
        mem_hi_o    <= ex_hi_i;
        mem_lo_o    <= ex_lo_i;
        wb_waddr_o  <= mem_waddr_o;
        wb_wdata_o  <= mem_wdata_o;
        wb_hi_o     <= mem_hi_o;
        wb_lo_o     <= mem_lo_o;
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
////////////////////////////////////////////////////////////////////////////
// execute_stage
// Decode/execute pipeline register and the ALU: add, subtract, logic,
// LUI, unsigned 32x32 multiply and HI/LO moves. HI/LO is forwarded
// from the memory and writeback stages.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module execute_stage import mips_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  var alu_op_e            alu_op_i,
    input  wire   [data_w-1:0]     op1_i,
    input  wire   [data_w-1:0]     op2_i,
    input  wire   [reg_addr_w-1:0] waddr_i,
    input  wire                    we_i,
    input  wire   [data_w-1:0]     hi_i,
    input  wire   [data_w-1:0]     lo_i,
    input  wire                    mem_whilo_i,
    input  wire   [data_w-1:0]     mem_hi_i,
    input  wire   [data_w-1:0]     mem_lo_i,
    input  wire                    wb_whilo_i,
    input  wire   [data_w-1:0]     wb_hi_i,
    input  wire   [data_w-1:0]     wb_lo_i,
    output logic                   ex_we_o,
    output logic  [reg_addr_w-1:0] ex_waddr_o,
    output logic  [data_w-1:0]     ex_wdata_o,
    output logic                   whilo_o,
    output logic  [data_w-1:0]     hi_o,
    output logic  [data_w-1:0]     lo_o
);

    alu_op_e               alu_op_q;
    logic                  we_q;
    logic [data_w-1:0]     op1_q;
    logic [data_w-1:0]     op2_q;
    logic [reg_addr_w-1:0] waddr_q;
    logic [data_w-1:0]     hi_fwd;
    logic [data_w-1:0]     lo_fwd;
    logic [2*data_w-1:0]   prod;

    // decode/execute register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_op_q <= alu_nop;
            we_q     <= 1'b0;
        end else begin
            alu_op_q <= alu_op_i;
            we_q     <= we_i;
        end
    end

    always_ff @(posedge clk) begin
        op1_q   <= op1_i;
        op2_q   <= op2_i;
        waddr_q <= waddr_i;
    end

    // newest pending hi/lo wins
    assign hi_fwd = mem_whilo_i ? mem_hi_i : (wb_whilo_i ? wb_hi_i : hi_i);
    assign lo_fwd = mem_whilo_i ? mem_lo_i : (wb_whilo_i ? wb_lo_i : lo_i);

    assign prod = {{data_w{1'b0}}, op1_q} * {{data_w{1'b0}}, op2_q};   // unsigned

    always_comb begin
        case (alu_op_q)
            alu_add:  ex_wdata_o = op1_q + op2_q;
            alu_sub:  ex_wdata_o = op1_q - op2_q;
            alu_and:  ex_wdata_o = op1_q & op2_q;
            alu_or:   ex_wdata_o = op1_q | op2_q;
            alu_xor:  ex_wdata_o = op1_q ^ op2_q;
            alu_lui:  ex_wdata_o = {op2_q[15:0], 16'h0000};
            alu_mfhi: ex_wdata_o = hi_fwd;
            alu_mflo: ex_wdata_o = lo_fwd;
            default:  ex_wdata_o = '0;
        endcase
    end

    always_comb begin
        whilo_o = 1'b0;
        hi_o    = hi_fwd;
        lo_o    = lo_fwd;
        case (alu_op_q)
            alu_multu: begin
                whilo_o = 1'b1;
                hi_o    = prod[2*data_w-1:data_w];
                lo_o    = prod[data_w-1:0];
            end
            alu_mthi: begin
                whilo_o = 1'b1;
                hi_o    = op1_q;       // lo keeps forwarded value
            end
            alu_mtlo: begin
                whilo_o = 1'b1;
                lo_o    = op1_q;
            end
            default: ;
        endcase
    end

    assign ex_we_o    = we_q;
    assign ex_waddr_o = waddr_q;

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
////////////////////////////////////////////////////////////////////////////
// decode_stage
// Instruction decoder: maps opcode/function to an ALU operation,
// extends the immediate and picks operands, forwarding from the
// execute and memory stages ahead of register file data.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module decode_stage import mips_pkg::*; (
    input  wire   [data_w-1:0]     inst_i,
    input  wire   [data_w-1:0]     rdata1_i,
    input  wire   [data_w-1:0]     rdata2_i,
    input  wire                    ex_we_i,
    input  wire   [reg_addr_w-1:0] ex_waddr_i,
    input  wire   [data_w-1:0]     ex_wdata_i,
    input  wire                    mem_we_i,
    input  wire   [reg_addr_w-1:0] mem_waddr_i,
    input  wire   [data_w-1:0]     mem_wdata_i,
    output logic                   re1_o,
    output logic  [reg_addr_w-1:0] raddr1_o,
    output logic                   re2_o,
    output logic  [reg_addr_w-1:0] raddr2_o,
    output alu_op_e                alu_op_o,
    output logic  [data_w-1:0]     op1_o,
    output logic  [data_w-1:0]     op2_o,
    output logic  [reg_addr_w-1:0] waddr_o,
    output logic                   we_o
);

    logic                  reg_form;
    logic                  wr;
    logic [data_w-1:0]     imm;

    always_comb begin
        case (inst_i[31:26])
            op_ori:   alu_op_o = alu_or;
            op_andi:  alu_op_o = alu_and;
            op_xori:  alu_op_o = alu_xor;
            op_addiu: alu_op_o = alu_add;
            op_lui:   alu_op_o = alu_lui;
            op_special: begin
                case (inst_i[5:0])
                    fn_addu:  alu_op_o = alu_add;
                    fn_subu:  alu_op_o = alu_sub;
                    fn_and:   alu_op_o = alu_and;
                    fn_or:    alu_op_o = alu_or;
                    fn_xor:   alu_op_o = alu_xor;
                    fn_multu: alu_op_o = alu_multu;
                    fn_mfhi:  alu_op_o = alu_mfhi;
                    fn_mflo:  alu_op_o = alu_mflo;
                    fn_mthi:  alu_op_o = alu_mthi;
                    fn_mtlo:  alu_op_o = alu_mtlo;
                    default:  alu_op_o = alu_nop;
                endcase
            end
            default:  alu_op_o = alu_nop;    // unknown encodings
        endcase
    end

    assign reg_form = inst_i[31:26] == op_special;

    // only addiu sign extends
    assign imm = (inst_i[31:26] == op_addiu) ? {{16{inst_i[15]}}, inst_i[15:0]}
                                             : {16'h0000, inst_i[15:0]};

    assign re1_o = !(alu_op_o inside {alu_nop, alu_lui, alu_mfhi, alu_mflo});
    assign re2_o = reg_form &&
                   (alu_op_o inside {alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_multu});
    assign wr    = alu_op_o inside {alu_add, alu_sub, alu_and, alu_or, alu_xor,
                                    alu_lui, alu_mfhi, alu_mflo};

    assign raddr1_o = inst_i[25:21];
    assign raddr2_o = inst_i[20:16];
    assign waddr_o  = reg_form ? inst_i[15:11] : inst_i[20:16];
    assign we_o     = wr && waddr_o != '0;    // $0 is never written

    // execute result first, then memory stage, then register file
    function automatic logic [data_w-1:0] pick_operand(
        input logic                  re,
        input logic [reg_addr_w-1:0] raddr,
        input logic [data_w-1:0]     rdata
    );
        if (re && ex_we_i && ex_waddr_i == raddr)
            return ex_wdata_i;
        if (re && mem_we_i && mem_waddr_i == raddr)
            return mem_wdata_i;
        return rdata;
    endfunction

    assign op1_o = pick_operand(re1_o, raddr1_o, rdata1_i);
    assign op2_o = reg_form ? pick_operand(re2_o, raddr2_o, rdata2_i) : imm;

endmodule

`default_nettype wire

// File: rtl/regfile.sv
////////////////////////////////////////////////////////////////////////////
// regfile
// 32 x 32 general register file, two read ports and one write port.
// Register zero reads as zero; a read of the register being written
// returns the write data in the same cycle.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module regfile import mips_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    we_i,
    input  wire   [reg_addr_w-1:0] waddr_i,
    input  wire   [data_w-1:0]     wdata_i,
    input  wire                    re1_i,
    input  wire   [reg_addr_w-1:0] raddr1_i,
    input  wire                    re2_i,
    input  wire   [reg_addr_w-1:0] raddr2_i,
    output logic  [data_w-1:0]     rdata1_o,
    output logic  [data_w-1:0]     rdata2_o
);

    logic [data_w-1:0] regs [1:reg_num-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    function automatic logic [data_w-1:0] read_port(
        input logic                  re,
        input logic [reg_addr_w-1:0] raddr
    );
        if (!re || raddr == '0)
            return '0;
        if (we_i && raddr == waddr_i)
            return wdata_i;        // write-through from writeback
        return regs[raddr];
    endfunction

    always_comb begin
        rdata1_o = read_port(re1_i, raddr1_i);
        rdata2_o = read_port(re2_i, raddr2_i);
    end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
////////////////////////////////////////////////////////////////////////////
// fetch_stage
// Program counter and ROM chip enable, plus the fetch/decode
// pipeline register. A zero word is passed on while the ROM is off.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module fetch_stage import mips_pkg::*; (
    input  wire                clk,
    input  wire                rst_n_i,
    input  wire   [data_w-1:0] rom_data_i,
    output logic  [data_w-1:0] rom_addr_o,
    output logic               rom_ce_o,
    output logic  [data_w-1:0] id_pc_o,
    output logic  [data_w-1:0] id_inst_o
);

    logic [data_w-1:0] pc;
    logic              ce;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ce <= 1'b0;
            pc <= pc_reset;
        end else begin
            ce <= 1'b1;            // rom on one cycle after release
            if (ce) begin
                pc <= pc + pc_step;
            end else begin
                pc <= pc_reset;
            end
        end
    end

    // fetch/decode register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_inst_o <= nop_inst;
        end else begin
            id_inst_o <= ce ? rom_data_i : nop_inst;
        end
    end

    always_ff @(posedge clk) begin
        id_pc_o <= pc;
    end

    assign rom_addr_o = pc;
    assign rom_ce_o   = ce;

endmodule

`default_nettype wire

// File: rtl/mips_pkg.sv
////////////////////////////////////////////////////////////////////////////
// mips_pkg
// Shared widths, reset values and encodings for the five-stage
// MIPS32 subset pipeline.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package mips_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_num    = 32;

    localparam logic [data_w-1:0] pc_step  = 32'd4;   // one word per fetch
    localparam logic [data_w-1:0] pc_reset = 32'h0000_0000;
    localparam logic [data_w-1:0] nop_inst = 32'h0000_0000;

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_addiu   = 6'b001001,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_xori    = 6'b001110,
        op_lui     = 6'b001111
    } opcode_e;

    // function field for op_special, inst[5:0]
    typedef enum logic [5:0] {
        fn_mfhi  = 6'b010000,
        fn_mthi  = 6'b010001,
        fn_mflo  = 6'b010010,
        fn_mtlo  = 6'b010011,
        fn_multu = 6'b011001,
        fn_addu  = 6'b100001,
        fn_subu  = 6'b100011,
        fn_and   = 6'b100100,
        fn_or    = 6'b100101,
        fn_xor   = 6'b100110
    } funct_e;

    typedef enum logic [3:0] {
        alu_nop,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_lui,
        alu_multu,
        alu_mfhi,
        alu_mflo,
        alu_mthi,
        alu_mtlo
    } alu_op_e;

endpackage

`default_nettype wire
